// ==== rtl/matrix_pkg.sv ====
package matrix_pkg;

    // panel geometry
    localparam int n_rows = 8;
    localparam int n_cols = 8;

    // glyphs held in the rom, higher numbers are blank
    localparam int n_scenes = 12;

    typedef logic [$clog2(n_rows)-1:0] row_idx_t;

    // bit 7 is the leftmost column
    typedef logic [n_cols-1:0] col_bits_t;

    typedef logic [3:0] scene_t;

    // row lines are active low
    localparam logic [n_rows-1:0] row_off = '1;

endpackage

// ==== rtl/row_scanner.sv ====
`timescale 1ns/1ps

module row_scanner
    import matrix_pkg::*;
#(
    parameter int scan_div = 4
)
(
    input  logic     clk,
    input  logic     rst,
    input  logic     st,
    output row_idx_t row_idx,
    output logic     row_tick,
    output logic     frame_start
);

    localparam int cnt_w = $clog2(scan_div);

    logic [cnt_w-1:0] cnt;
    logic             run;   // set on the first enabled cycle
    logic             last_row;

    assign last_row = (row_idx == row_idx_t'(n_rows - 1));

    // last cycle of the current row
    assign row_tick = st && (cnt == cnt_w'(scan_div - 1));

    // also fires on the first cycle after enable so the first frame
    // picks up the current scene number
    assign frame_start = st && (!run || (row_tick && last_row));

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cnt     <= '0;
            row_idx <= '0;
            run     <= 1'b0;
        end
        else if (!st)
        begin
            cnt     <= '0;   // restart the scan from row 0
            row_idx <= '0;
            run     <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
            if (row_tick)
            begin
                cnt     <= '0;
                row_idx <= last_row ? '0 : row_idx + 1'b1;
            end
            else
            begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/scene_latch.sv ====
`timescale 1ns/1ps

module scene_latch
    import matrix_pkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  logic   st,
    input  scene_t num,
    input  logic   frame_start,
    output scene_t scene
);

    // a new scene only between frames, never mid-scan
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scene <= '0;
        end
        else if (!st)
        begin
            scene <= '0;
        end
        else if (frame_start)
        begin
            scene <= num;
        end
    end

endmodule

// ==== rtl/glyph_rom.sv ====
`timescale 1ns/1ps

module glyph_rom
    import matrix_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  scene_t    scene,
    input  row_idx_t  row_idx,
    output col_bits_t pattern,
    output row_idx_t  pattern_row
);

    function automatic col_bits_t glyph_row(input scene_t s, input row_idx_t r);
        col_bits_t p;
        p = '0;
        case (s)
            // discs of growing size
            4'd0:
                case (r)
                    3'd2, 3'd5: p = 8'b0001_1000;
                    3'd3, 3'd4: p = 8'b0011_1100;
                    default:    p = '0;
                endcase
            4'd1:
                case (r)
                    3'd2, 3'd5: p = 8'b0011_1000;
                    3'd3, 3'd4: p = 8'b0111_1100;
                    default:    p = '0;
                endcase
            4'd2:
                case (r)
                    3'd2, 3'd5: p = 8'b0011_1100;
                    3'd3, 3'd4: p = 8'b0111_1110;
                    default:    p = '0;
                endcase
            4'd3:
                case (r)
                    3'd1, 3'd6:             p = 8'b0011_1100;
                    3'd2, 3'd3, 3'd4, 3'd5: p = 8'b0111_1110;
                    default:                p = '0;
                endcase
            4'd4:
                case (r)
                    3'd0, 3'd7: p = 8'b0011_1100;
                    3'd1, 3'd6: p = 8'b0111_1110;
                    default:    p = 8'b1111_1111;
                endcase
            4'd5: p = 8'b1111_1111;   // all lit
            4'd6:
                case (r)
                    3'd0: p = 8'b1100_0011;
                    3'd1: p = 8'b1110_0011;
                    3'd2: p = 8'b1111_0001;
                    3'd3: p = 8'b1110_0011;
                    3'd4: p = 8'b1100_0111;
                    3'd5: p = 8'b1110_0111;
                    3'd6: p = 8'b1111_0111;
                    default: p = 8'b1111_1011;
                endcase
            4'd7:
                case (r)
                    3'd1: p = 8'b0000_0001;
                    3'd2: p = 8'b1000_0001;
                    3'd3: p = 8'b1100_0011;
                    3'd4: p = 8'b1000_0011;
                    3'd5: p = 8'b1100_0111;
                    3'd6: p = 8'b1110_0111;
                    3'd7: p = 8'b1111_0011;
                    default: p = '0;
                endcase
            4'd8:
                case (r)
                    3'd1: p = 8'b0011_1000;
                    3'd2: p = 8'b0100_0100;
                    3'd3: p = 8'b0101_1010;
                    3'd4: p = 8'b0100_1010;
                    3'd5: p = 8'b0011_0010;
                    3'd6: p = 8'b1100_0100;
                    3'd7: p = 8'b0011_1000;
                    default: p = '0;
                endcase
            4'd9:
                case (r)
                    3'd2: p = 8'b0110_0000;
                    3'd3: p = 8'b1111_1100;
                    3'd4: p = 8'b0011_1111;
                    3'd5: p = 8'b0011_1110;
                    3'd6: p = 8'b0001_1100;
                    default: p = '0;
                endcase
            4'd10:
                case (r)
                    3'd2:       p = 8'b0001_1000;
                    3'd3:       p = 8'b0011_1100;
                    3'd4, 3'd5: p = 8'b0111_1110;
                    3'd6:       p = 8'b0010_0100;
                    default:    p = '0;
                endcase
            4'd11:
                case (r)
                    3'd0: p = 8'b1110_0000;
                    3'd1: p = 8'b0110_0000;
                    3'd2: p = 8'b1110_0000;
                    3'd3: p = 8'b0011_0000;
                    3'd4: p = 8'b0011_0001;
                    3'd5: p = 8'b0011_0011;
                    3'd6: p = 8'b0011_1110;
                    default: p = 8'b0001_1100;
                endcase
            default: p = '0;
        endcase
        return p;
    endfunction

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            pattern     <= '0;
            pattern_row <= '0;
        end
        else
        begin
            // unused scene codes stay dark
            pattern     <= (scene < scene_t'(n_scenes)) ? glyph_row(scene, row_idx) : '0;
            pattern_row <= row_idx;   // keeps the row aligned with its pattern
        end
    end

endmodule

// ==== rtl/color_driver.sv ====
`timescale 1ns/1ps

module color_driver
    import matrix_pkg::*;
(
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  logic              temp,
    input  col_bits_t         pattern,
    input  row_idx_t          pattern_row,
    output logic [n_rows-1:0] row,
    output col_bits_t         colg,
    output col_bits_t         colr
);

    logic [n_rows-1:0] row_sel;

    // one-cold, active low
    assign row_sel = ~(n_rows'(1) << pattern_row);

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= row_off;
            colg <= '0;
            colr <= '0;
        end
        else if (!st)
        begin
            row  <= row_off;   // blanked
            colg <= '0;
            colr <= '0;
        end
        else
        begin
            row  <= row_sel;
            colg <= pattern;
            // red over green shows amber during an alarm
            colr <= temp ? pattern : '0;
        end
    end

endmodule

// ==== rtl/matrix_display.sv ====
`timescale 1ns/1ps

module matrix_display
    import matrix_pkg::*;
#(
    parameter int scan_div = 4   // clk cycles per row, at least 4
)
(
    input  logic              clk,
    input  logic              rst,
    input  logic              st,
    input  logic              temp,
    input  scene_t            num,
    output logic [n_rows-1:0] row,
    output col_bits_t         colg,
    output col_bits_t         colr
);

    row_idx_t  row_idx;
    logic      frame_start;
    scene_t    scene;
    col_bits_t pattern;
    row_idx_t  pattern_row;

    row_scanner #(
        .scan_div    (scan_div)
    ) scanner_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st),
        .row_idx     (row_idx),
        .row_tick    (),
        .frame_start (frame_start)
    );

    scene_latch latch_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st),
        .num         (num),
        .frame_start (frame_start),
        .scene       (scene)
    );

    glyph_rom rom_i (
        .clk         (clk),
        .rst         (rst),
        .scene       (scene),
        .row_idx     (row_idx),
        .pattern     (pattern),
        .pattern_row (pattern_row)
    );

    color_driver driver_i (
        .clk         (clk),
        .rst         (rst),
        .st          (st),
        .temp        (temp),
        .pattern     (pattern),
        .pattern_row (pattern_row),
        .row         (row),
        .colg        (colg),
        .colr        (colr)
    );

endmodule

// ==== tb/matrix_display_chk.sv ====
`timescale 1ns/1ps

module matrix_display_chk
    import matrix_pkg::*;
(
    input logic              clk,
    input logic              rst,
    input logic              st,
    input logic [n_rows-1:0] row,
    input col_bits_t         colg,
    input col_bits_t         colr
);

    // active low select, at most one row on
    row_code_ok: assert property (@(posedge clk) disable iff (rst)
        (row == row_off) || $onehot(~row))
        else $error("row select is neither one-cold nor all off");

    // red is a copy of green or dark
    red_follows_green: assert property (@(posedge clk) disable iff (rst)
        (colr == colg) || (colr == '0))
        else $error("red columns differ from green columns");

    // held low for two edges means the outputs are blank
    blank_when_off: assert property (@(posedge clk) disable iff (rst)
        (!st && !$past(st)) |-> (row == row_off && colg == '0 && colr == '0))
        else $error("outputs not blank while disabled");

endmodule

bind matrix_display matrix_display_chk chk_i (
    .clk  (clk),
    .rst  (rst),
    .st   (st),
    .row  (row),
    .colg (colg),
    .colr (colr)
);

// ==== tb/tb_matrix_display.sv ====
`timescale 1ns/1ps

module tb_matrix_display
    import matrix_pkg::*;
();

    localparam int scan_div    = 4;
    localparam int row_limit   = 4 * scan_div;
    localparam int frame_limit = 3 * n_rows * scan_div;
    localparam int n_entries   = 14;

    typedef struct packed {
        scene_t      scene;
        logic        temp;
        logic [63:0] rows;   // row 0 in the top byte
    } entry_t;

    localparam entry_t glyph_table [n_entries] = '{
        '{4'd0,  1'b0, 64'h0000_183C_3C18_0000},
        '{4'd1,  1'b1, 64'h0000_387C_7C38_0000},
        '{4'd2,  1'b0, 64'h0000_3C7E_7E3C_0000},
        '{4'd3,  1'b1, 64'h003C_7E7E_7E7E_3C00},
        '{4'd4,  1'b0, 64'h3C7E_FFFF_FFFF_7E3C},
        '{4'd5,  1'b1, 64'hFFFF_FFFF_FFFF_FFFF},
        '{4'd6,  1'b0, 64'hC3E3_F1E3_C7E7_F7FB},
        '{4'd7,  1'b1, 64'h0001_81C3_83C7_E7F3},
        '{4'd8,  1'b0, 64'h0038_445A_4A32_C438},
        '{4'd9,  1'b1, 64'h0000_60FC_3F3E_1C00},
        '{4'd10, 1'b0, 64'h0000_183C_7E7E_2400},
        '{4'd11, 1'b1, 64'hE060_E030_3133_3E1C},
        '{4'd12, 1'b0, 64'h0000_0000_0000_0000},
        '{4'd15, 1'b1, 64'h0000_0000_0000_0000}
    };

    logic              clk;
    logic              rst;
    logic              st;
    logic              temp;
    scene_t            num;
    logic [n_rows-1:0] row;
    col_bits_t         colg;
    col_bits_t         colr;

    logic [n_rows-1:0] cur_row;
    logic [n_rows-1:0] prev_row;
    col_bits_t         cur_g;
    col_bits_t         cur_r;
    col_bits_t         got_g [n_rows];
    col_bits_t         got_r [n_rows];
    int                change_at;

    matrix_display #(
        .scan_div (scan_div)
    ) dut_i (
        .clk  (clk),
        .rst  (rst),
        .st   (st),
        .temp (temp),
        .num  (num),
        .row  (row),
        .colg (colg),
        .colr (colr)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // all row lines high except the selected one
    function automatic logic [7:0] row_code(input int r);
        logic [7:0] code;
        code    = row_off;
        code[r] = 1'b0;
        return code;
    endfunction

    function automatic col_bits_t expected_row(input logic [63:0] rows, input int r);
        return rows[8*(7-r) +: 8];
    endfunction

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout while waiting for %s", what);
        stop_run();
    endtask

    task automatic check(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
        begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    // one sample per clock on the falling edge
    task automatic next_cycle();
        prev_row = cur_row;
        @(negedge clk);
        cur_row = row;
        cur_g   = colg;
        cur_r   = colr;
    endtask

    task automatic wait_row_start(input int r);
        int n;
        n = 0;
        while (!(cur_row == row_code(r) && prev_row != row_code(r)))
        begin
            next_cycle();
            n++;
            if (n > frame_limit)
                stop_on_timeout($sformatf("start of row %0d", r));
        end
    endtask

    task automatic check_blank(input int cycles);
        repeat (cycles)
        begin
            next_cycle();
            check("row", cur_row, row_off);
            check("colg", cur_g, 8'd0);
            check("colr", cur_r, 8'd0);
        end
    endtask

    // keeps the last sample of each row and may change num mid-frame
    task automatic capture_frame(input int change, input scene_t new_num);
        int n;
        int k;
        n = 0;
        wait_row_start(0);
        for (int r = 0; r < n_rows; r++)
        begin
            check("row", cur_row, row_code(r));
            k = 0;
            while (cur_row == row_code(r))
            begin
                got_g[r] = cur_g;
                got_r[r] = cur_r;
                if (n == change)
                    num = new_num;
                next_cycle();
                n++;
                k++;
                if (k > row_limit)
                    stop_on_timeout($sformatf("end of row %0d", r));
            end
        end
    endtask

    task automatic check_frame(input logic [63:0] rows, input logic alarm);
        col_bits_t exp;
        for (int r = 0; r < n_rows; r++)
        begin
            exp = expected_row(rows, r);
            check($sformatf("colg row %0d", r), got_g[r], exp);
            check($sformatf("colr row %0d", r), got_r[r], alarm ? exp : 8'd0);
        end
    endtask

    initial
    begin
        void'($urandom(91));
        rst      = 1'b1;
        st       = 1'b0;
        temp     = 1'b0;
        num      = '0;
        cur_row  = row_off;
        prev_row = row_off;
        cur_g    = '0;
        cur_r    = '0;
        repeat (4) next_cycle();
        rst = 1'b0;

        check_blank(8);
        st = 1'b1;

        for (int i = 0; i < n_entries; i++)
        begin
            num  = glyph_table[i].scene;
            temp = glyph_table[i].temp;
            capture_frame(-1, '0);   // frame may still hold the previous scene
            capture_frame(-1, '0);
            check_frame(glyph_table[i].rows, temp);
        end

        // scene change inside a frame
        num = glyph_table[6].scene;
        capture_frame(-1, '0);
        change_at = int'($urandom % 27) + 1;
        capture_frame(change_at, glyph_table[9].scene);
        check_frame(glyph_table[6].rows, temp);
        capture_frame(-1, '0);
        check_frame(glyph_table[9].rows, temp);

        // alarm toggled halfway through row 3
        wait_row_start(3);
        next_cycle();
        temp = ~temp;
        next_cycle();
        check("row", cur_row, row_code(3));
        check("colg", cur_g, expected_row(glyph_table[9].rows, 3));
        check("colr", cur_r, temp ? expected_row(glyph_table[9].rows, 3) : 8'd0);
        capture_frame(-1, '0);
        check_frame(glyph_table[9].rows, temp);

        // disable for a few rows and restart
        st = 1'b0;
        next_cycle();
        check_blank(12);
        st = 1'b1;
        change_at = 0;
        while (cur_row == row_off)
        begin
            next_cycle();
            change_at++;
            if (change_at > row_limit)
                stop_on_timeout("first row after enable");
        end
        check("row", cur_row, row_code(0));
        capture_frame(-1, '0);
        check_frame(glyph_table[9].rows, temp);

        // remaining blank codes
        for (int s = 13; s <= 14; s++)
        begin
            num  = scene_t'(s);
            temp = 1'b1;
            capture_frame(-1, '0);
            capture_frame(-1, '0);
            check_frame(64'h0, temp);
        end

        $display("No errors");
        $finish;
    end

endmodule

// ==== all.f ====
rtl/matrix_pkg.sv
rtl/row_scanner.sv
rtl/scene_latch.sv
rtl/glyph_rom.sv
rtl/color_driver.sv
rtl/matrix_display.sv
tb/matrix_display_chk.sv
tb/tb_matrix_display.sv

// ==== Makefile ====
TOP = tb_matrix_display

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "No errors"

clean:
	rm -rf obj_dir

.PHONY: sim clean
